//--- include/eth_frame_consts.svh
// Beat buffer depth, frame limit, pattern geometry, inter-frame gap and event queue depth
`ifndef ETH_FRAME_CONSTS_SVH
`define ETH_FRAME_CONSTS_SVH

// Beat buffer entries and credits after reset
`define ETH_FIFO_DEPTH 128

// Longest legal frame in bytes
// Also the credit needed before a frame is admitted
`define ETH_MAX_FRAME 64

// Number of patterns
`define ETH_NUM_PATTERNS 3

// Bytes compared from frame offset 0
`define ETH_PAT_LEN 16

// Idle transmit cycles after each tlast
`define ETH_IFG 4

// Event queue entries
`define ETH_EVT_DEPTH 4

`endif

//--- rtl/eth_frame_pkg.sv
// Stream beat, pattern byte, pattern word and match event types
`include "eth_frame_consts.svh"

package eth_frame_pkg;

	// One byte of the stream with its sideband bits
	typedef struct packed {
		logic [7:0] data;
		logic       user;
		logic       last;
	} eth_beat_t;

	// Pattern byte with per-bit care mask
	typedef struct packed {
		logic [7:0] value;
		logic [7:0] care;
	} eth_pat_byte_t;

	// Bytes of all patterns at one offset
	// Element p belongs to pattern p
	typedef eth_pat_byte_t [`ETH_NUM_PATTERNS-1:0] eth_pat_word_t;

	// Queued detection
	typedef struct packed {
		logic [63:0]                  stamp;
		logic [`ETH_NUM_PATTERNS-1:0] mask;
	} eth_match_evt_t;

endpackage

//--- rtl/eth_beat_if.sv
// Credit-flow link between the receive stage and the beat buffer
`timescale 1ns/10ps

interface eth_beat_if;

	// Beat from receive stage
	logic       valid;
	logic [7:0] data;
	logic       user;
	logic       last;

	// One pulse per beat freed in the buffer
	logic       credit;

	// Receive side sends beats and collects credits
	modport producer (
		output valid,
		output data,
		output user,
		output last,
		input  credit
	);

	// Buffer side stores beats and hands credits back
	modport buffer (
		input  valid,
		input  data,
		input  user,
		input  last,
		output credit
	);

endinterface

//--- rtl/eth_frame_fifo.sv
// Synchronous first-word-fall-through FIFO with a type-parameterized payload
`timescale 1ns/10ps

module eth_frame_fifo #(
	parameter type item_t = logic [7:0],
	parameter int  depth  = 4
) (
	input  logic  s_axi_clk,
	input  logic  reset,
	input  logic  push,
	input  item_t push_item,
	input  logic  pop,
	output item_t pop_item,
	output logic  not_empty,
	output logic  full
);
	localparam int aw = (depth > 1) ? $clog2(depth) : 1;
	localparam int cw = $clog2(depth + 1);

	item_t         mem [depth];
	logic [aw-1:0] wr_ptr;
	logic [aw-1:0] rd_ptr;
	logic [cw-1:0] count;
	logic          do_push;
	logic          do_pop;

	// Writes to a full queue and reads from an empty one are ignored
	assign do_push   = push && !full;
	assign do_pop    = pop && not_empty;
	assign not_empty = (count != '0);
	assign full      = (count == cw'(depth));

	// Head is always presented
	assign pop_item = mem[rd_ptr];

	always_ff @(posedge s_axi_clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// Pointers wrap at depth
			if (do_push)
				wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			// Occupancy
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage
	always_ff @(posedge s_axi_clk) begin
		if (do_push)
			mem[wr_ptr] <= push_item;
	end

endmodule

//--- rtl/eth_frame_rx.sv
// Receive stage with credit counter, whole-frame admission, beat register and drop counter
`timescale 1ns/10ps
`include "eth_frame_consts.svh"

module eth_frame_rx (
	input  logic         s_axi_clk,
	input  logic         reset,
	input  logic [7:0]   s_axis_tdata,
	input  logic         s_axis_tuser,
	input  logic         s_axis_tlast,
	input  logic         s_axis_tvalid,
	eth_beat_if.producer beat_out,
	output logic [15:0]  drop_count
);
	localparam int cw = $clog2(`ETH_FIFO_DEPTH + 1);

	logic [cw-1:0] credit_count;
	logic [cw-1:0] credit_avail;
	logic          in_frame;
	logic          admit_q;
	logic          sof;
	logic          admit_now;

	// Beat on the link this cycle is not yet taken off the count
	assign credit_avail = credit_count - cw'(beat_out.valid);

	// First byte of a frame
	assign sof = s_axis_tvalid && !in_frame;

	// Decision made at frame start, held until tlast
	assign admit_now = sof ? (credit_avail >= cw'(`ETH_MAX_FRAME)) : admit_q;

	always_ff @(posedge s_axi_clk) begin
		if (reset) begin
			credit_count   <= cw'(`ETH_FIFO_DEPTH);
			in_frame       <= 1'b0;
			admit_q        <= 1'b0;
			drop_count     <= '0;
			beat_out.valid <= 1'b0;
		end else begin
			// Returned credits in, spent credits out
			credit_count <= credit_count + cw'(beat_out.credit) - cw'(beat_out.valid);
			if (s_axis_tvalid) begin
				in_frame <= !s_axis_tlast;
				admit_q  <= admit_now;
			end
			// Count refused frames once, at their first byte
			if (sof && !admit_now)
				drop_count <= drop_count + 1'b1;
			beat_out.valid <= s_axis_tvalid && admit_now;
		end
	end

	// Beat payload
	always_ff @(posedge s_axi_clk) begin
		beat_out.data <= s_axis_tdata;
		beat_out.user <= s_axis_tuser;
		beat_out.last <= s_axis_tlast;
	end

endmodule

//--- rtl/eth_frame_loop.sv
// Beat buffer between receive and transmit with credit return per pop
`timescale 1ns/10ps
`include "eth_frame_consts.svh"

module eth_frame_loop (
	input  logic                     s_axi_clk,
	input  logic                     reset,
	eth_beat_if.buffer               beat_in,
	output eth_frame_pkg::eth_beat_t beat,
	output logic                     beat_valid,
	input  logic                     beat_pop
);
	import eth_frame_pkg::*;

	eth_beat_t push_beat;
	logic      pop_ok;

	// Link fields to one stored beat
	assign push_beat = '{data: beat_in.data, user: beat_in.user, last: beat_in.last};

	// Only real pops free an entry
	assign pop_ok = beat_pop && beat_valid;

	// Credits keep the queue from overflowing
	eth_frame_fifo #(
		.item_t (eth_beat_t),
		.depth  (`ETH_FIFO_DEPTH)
	) u_beat_fifo (
		.s_axi_clk (s_axi_clk),
		.reset     (reset),
		.push      (beat_in.valid),
		.push_item (push_beat),
		.pop       (pop_ok),
		.pop_item  (beat),
		.not_empty (beat_valid),
		.full      ()
	);

	// Credit goes back the cycle after the pop
	always_ff @(posedge s_axi_clk) begin
		if (reset)
			beat_in.credit <= 1'b0;
		else
			beat_in.credit <= pop_ok;
	end

endmodule

//--- rtl/eth_frame_tx.sv
// Transmit stage with output register and inter-frame gap counter
`timescale 1ns/10ps
`include "eth_frame_consts.svh"

module eth_frame_tx (
	input  logic                     s_axi_clk,
	input  logic                     reset,
	input  eth_frame_pkg::eth_beat_t beat,
	input  logic                     beat_valid,
	output logic                     beat_pop,
	output logic [7:0]               m_axis_tdata,
	output logic                     m_axis_tuser,
	output logic                     m_axis_tlast,
	output logic                     m_axis_tvalid,
	input  logic                     m_axis_tready
);
	import eth_frame_pkg::*;

	localparam int gw = $clog2(`ETH_IFG + 1);

	eth_beat_t     out_beat;
	logic          out_valid;
	logic          out_accept;
	logic [gw-1:0] gap_count;

	assign out_accept = out_valid && m_axis_tready;

	// Refill when empty or just taken, never straight after a tlast
	// and not while the gap is running
	assign beat_pop = beat_valid && (gap_count == '0) &&
		(!out_valid || (out_accept && !out_beat.last));

	always_ff @(posedge s_axi_clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			gap_count <= '0;
		end else begin
			if (beat_pop)
				out_valid <= 1'b1;
			else if (out_accept)
				out_valid <= 1'b0;
			// Loaded one short since the pop adds a cycle before tvalid
			if (out_accept && out_beat.last)
				gap_count <= gw'(`ETH_IFG - 1);
			else if (gap_count != '0)
				gap_count <= gap_count - 1'b1;
		end
	end

	// Held while tready is low
	always_ff @(posedge s_axi_clk) begin
		if (beat_pop)
			out_beat <= beat;
	end

	assign m_axis_tdata  = out_beat.data;
	assign m_axis_tuser  = out_beat.user;
	assign m_axis_tlast  = out_beat.last;
	assign m_axis_tvalid = out_valid;

endmodule

//--- rtl/eth_frame_pattern_mem.sv
// Pattern store with byte-wise configuration write and per-offset read
`timescale 1ns/10ps
`include "eth_frame_consts.svh"

module eth_frame_pattern_mem (
	input  logic                             s_axi_clk,
	input  logic                             cfg_we,
	input  logic [1:0]                       cfg_pattern,
	input  logic [$clog2(`ETH_PAT_LEN)-1:0]  cfg_offset,
	input  eth_frame_pkg::eth_pat_byte_t     cfg_byte,
	input  logic [$clog2(`ETH_PAT_LEN)-1:0]  rd_offset,
	output eth_frame_pkg::eth_pat_word_t     rd_word
);
	import eth_frame_pkg::*;

	// One word per offset, one byte per pattern
	eth_pat_word_t mem [`ETH_PAT_LEN];

	always_ff @(posedge s_axi_clk) begin
		// Pattern numbers past the last are ignored
		if (cfg_we && (int'(cfg_pattern) < `ETH_NUM_PATTERNS))
			mem[cfg_offset][cfg_pattern] <= cfg_byte;
		// Registered read, all patterns at once
		rd_word <= mem[rd_offset];
	end

endmodule

//--- rtl/eth_frame_matcher.sv
// Masked pattern compare over the frame head and timestamped event queue
`timescale 1ns/10ps
`include "eth_frame_consts.svh"

module eth_frame_matcher (
	input  logic                               s_axi_clk,
	input  logic                               reset,
	input  logic [7:0]                         s_axis_tdata,
	input  logic                               s_axis_tlast,
	input  logic                               s_axis_tvalid,
	input  logic [63:0]                        current_time,
	input  logic [`ETH_NUM_PATTERNS-1:0]       match_en,
	output logic [$clog2(`ETH_PAT_LEN)-1:0]    rd_offset,
	input  eth_frame_pkg::eth_pat_word_t       rd_word,
	output logic                               evt_valid,
	input  logic                               evt_ready,
	output logic [63:0]                        evt_time,
	output logic [`ETH_NUM_PATTERNS-1:0]       evt_mask
);
	import eth_frame_pkg::*;

	localparam int aw = $clog2(`ETH_PAT_LEN);
	localparam int ow = $clog2(`ETH_PAT_LEN + 1);
	localparam int np = `ETH_NUM_PATTERNS;

	// Byte position in frame, saturates past the compared head
	logic [ow-1:0]  offset;

	// Byte delayed to meet the memory read
	logic           d_valid;
	logic           d_last;
	logic           d_first;
	logic           d_cmp;
	logic           d_long;
	logic [7:0]     d_data;
	logic [63:0]    d_time;
	logic [np-1:0]  d_en;

	// Running frame state
	logic [np-1:0]  hits;
	logic [np-1:0]  hit_next;
	logic [63:0]    frame_time;
	logic [63:0]    stamp_next;

	// Event side
	logic           evt_push;
	eth_match_evt_t evt_item;
	eth_match_evt_t evt_head;
	logic           evt_full;

	assign rd_offset = offset[aw-1:0];

	always_ff @(posedge s_axi_clk) begin
		if (reset) begin
			offset  <= '0;
			d_valid <= 1'b0;
		end else begin
			d_valid <= s_axis_tvalid;
			if (s_axis_tvalid) begin
				if (s_axis_tlast)
					offset <= '0;
				else if (offset != ow'(`ETH_PAT_LEN))
					offset <= offset + 1'b1;
			end
		end
	end

	// Stage 1 payload
	always_ff @(posedge s_axi_clk) begin
		d_last  <= s_axis_tlast;
		d_data  <= s_axis_tdata;
		d_first <= (offset == '0);
		d_cmp   <= (offset < ow'(`ETH_PAT_LEN));
		// Frame reaches the full head with this byte
		d_long  <= (offset >= ow'(`ETH_PAT_LEN - 1));
		d_time  <= current_time;
		d_en    <= match_en;
	end

	// Start from the enables at frame start, drop a pattern on any cared bit that differs
	always_comb begin
		hit_next = d_first ? d_en : hits;
		for (int p = 0; p < np; p++) begin
			if (d_cmp && (((d_data ^ rd_word[p].value) & rd_word[p].care) != 8'h00))
				hit_next[p] = 1'b0;
		end
	end

	assign stamp_next = d_first ? d_time : frame_time;

	always_ff @(posedge s_axi_clk) begin
		if (reset) begin
			hits     <= '0;
			evt_push <= 1'b0;
		end else begin
			if (d_valid)
				hits <= hit_next;
			// Short frames never report
			evt_push <= d_valid && d_last && d_long && (|hit_next);
		end
	end

	// Stage 2 payload
	always_ff @(posedge s_axi_clk) begin
		if (d_valid && d_first)
			frame_time <= d_time;
		evt_item <= '{stamp: stamp_next, mask: hit_next};
	end

	// Event lost when the queue is full
	eth_frame_fifo #(
		.item_t (eth_match_evt_t),
		.depth  (`ETH_EVT_DEPTH)
	) u_evt_fifo (
		.s_axi_clk (s_axi_clk),
		.reset     (reset),
		.push      (evt_push && !evt_full),
		.push_item (evt_item),
		.pop       (evt_valid && evt_ready),
		.pop_item  (evt_head),
		.not_empty (evt_valid),
		.full      (evt_full)
	);

	assign evt_time = evt_head.stamp;
	assign evt_mask = evt_head.mask;

endmodule

//--- rtl/eth_frame_detector.sv
// Frame detector top level joining receive, buffer, transmit, pattern store and matcher
`timescale 1ns/10ps
`include "eth_frame_consts.svh"

module eth_frame_detector (
	input  logic                              s_axi_clk,
	input  logic                              reset,
	// Receive stream from MAC
	input  logic [7:0]                        s_axis_tdata,
	input  logic                              s_axis_tuser,
	input  logic                              s_axis_tlast,
	input  logic                              s_axis_tvalid,
	// Transmit stream to MAC
	output logic [7:0]                        m_axis_tdata,
	output logic                              m_axis_tuser,
	output logic                              m_axis_tlast,
	output logic                              m_axis_tvalid,
	input  logic                              m_axis_tready,
	// Pattern configuration
	input  logic                              cfg_we,
	input  logic [1:0]                        cfg_pattern,
	input  logic [$clog2(`ETH_PAT_LEN)-1:0]   cfg_offset,
	input  eth_frame_pkg::eth_pat_byte_t      cfg_byte,
	input  logic [`ETH_NUM_PATTERNS-1:0]      match_en,
	// Timestamp source
	input  logic [63:0]                       current_time,
	// Event queue head
	output logic                              evt_valid,
	input  logic                              evt_ready,
	output logic [63:0]                       evt_time,
	output logic [`ETH_NUM_PATTERNS-1:0]      evt_mask,
	// Frames refused for lack of credit
	output logic [15:0]                       drop_count
);
	import eth_frame_pkg::*;

	eth_beat_t                       beat;
	logic                            beat_valid;
	logic                            beat_pop;
	logic [$clog2(`ETH_PAT_LEN)-1:0] rd_offset;
	eth_pat_word_t                   rd_word;

	// Receive stage to buffer
	eth_beat_if beat_link ();

	eth_frame_rx u_eth_frame_rx (
		.s_axi_clk     (s_axi_clk),
		.reset         (reset),
		.s_axis_tdata  (s_axis_tdata),
		.s_axis_tuser  (s_axis_tuser),
		.s_axis_tlast  (s_axis_tlast),
		.s_axis_tvalid (s_axis_tvalid),
		.beat_out      (beat_link),
		.drop_count    (drop_count)
	);

	eth_frame_loop u_eth_frame_loop (
		.s_axi_clk  (s_axi_clk),
		.reset      (reset),
		.beat_in    (beat_link),
		.beat       (beat),
		.beat_valid (beat_valid),
		.beat_pop   (beat_pop)
	);

	eth_frame_tx u_eth_frame_tx (
		.s_axi_clk     (s_axi_clk),
		.reset         (reset),
		.beat          (beat),
		.beat_valid    (beat_valid),
		.beat_pop      (beat_pop),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tuser  (m_axis_tuser),
		.m_axis_tlast  (m_axis_tlast),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tready (m_axis_tready)
	);

	// Matching runs on the raw receive stream, before admission
	eth_frame_pattern_mem u_eth_frame_pattern_mem (
		.s_axi_clk   (s_axi_clk),
		.cfg_we      (cfg_we),
		.cfg_pattern (cfg_pattern),
		.cfg_offset  (cfg_offset),
		.cfg_byte    (cfg_byte),
		.rd_offset   (rd_offset),
		.rd_word     (rd_word)
	);

	eth_frame_matcher u_eth_frame_matcher (
		.s_axi_clk     (s_axi_clk),
		.reset         (reset),
		.s_axis_tdata  (s_axis_tdata),
		.s_axis_tlast  (s_axis_tlast),
		.s_axis_tvalid (s_axis_tvalid),
		.current_time  (current_time),
		.match_en      (match_en),
		.rd_offset     (rd_offset),
		.rd_word       (rd_word),
		.evt_valid     (evt_valid),
		.evt_ready     (evt_ready),
		.evt_time      (evt_time),
		.evt_mask      (evt_mask)
	);

endmodule

//--- tests/eth_frame_detector_sva.sv
// Bound assertions on credit accounting, inter-frame gap and transmit state after reset
`timescale 1ns/10ps
`include "eth_frame_consts.svh"

module eth_frame_detector_sva #(
	parameter int cw      = $clog2(`ETH_FIFO_DEPTH + 1),
	parameter bit tx_side = 1'b0
) (
	input logic          clk,
	input logic          reset,
	input logic [cw-1:0] credit_count,
	input logic          link_valid,
	input logic          tx_valid,
	input logic          tx_ready,
	input logic          tx_last
);
	localparam int gw = $clog2(`ETH_IFG + 1);

	generate
		if (tx_side) begin : g_tx
			// Idle cycles still owed after an accepted tlast
			logic [gw-1:0] gap_left;

			always_ff @(posedge clk) begin
				if (reset)
					gap_left <= '0;
				else if (tx_valid && tx_ready && tx_last)
					gap_left <= gw'(`ETH_IFG);
				else if (gap_left != '0)
					gap_left <= gap_left - 1'b1;
			end

			gap_hold: assert property (@(posedge clk) disable iff (reset)
				tx_valid |-> (gap_left == '0))
				else $error("Transmit valid inside the inter-frame gap");

			reset_idle: assert property (@(posedge clk)
				reset |=> !tx_valid)
				else $error("Transmit valid high right after reset");
		end else begin : g_rx
			// Returns never push the count past the buffer size
			credit_bound: assert property (@(posedge clk) disable iff (reset)
				credit_count <= cw'(`ETH_FIFO_DEPTH))
				else $error("Credit count above buffer depth");

			// A beat on the link always has a credit behind it
			credit_spend: assert property (@(posedge clk) disable iff (reset)
				link_valid |-> (credit_count != '0))
				else $error("Beat sent on the link with no credit left");
		end
	endgenerate

endmodule

// Credit checks on the receive stage
bind eth_frame_rx eth_frame_detector_sva #(.tx_side(1'b0)) u_rx_sva (
	.clk          (s_axi_clk),
	.reset        (reset),
	.credit_count (credit_count),
	.link_valid   (beat_out.valid),
	.tx_valid     (1'b0),
	.tx_ready     (1'b0),
	.tx_last      (1'b0)
);

// Gap and reset checks on the transmit stage
bind eth_frame_tx eth_frame_detector_sva #(.tx_side(1'b1)) u_tx_sva (
	.clk          (s_axi_clk),
	.reset        (reset),
	.credit_count ('0),
	.link_valid   (1'b0),
	.tx_valid     (m_axis_tvalid),
	.tx_ready     (m_axis_tready),
	.tx_last      (m_axis_tlast)
);

//--- tests/eth_frame_detector_tb.sv
// Frame detector testbench with pattern and frame tables, reference model, compare tasks and timeout
`timescale 1ns/10ps
`include "eth_frame_consts.svh"

module eth_frame_detector_tb;
	import eth_frame_pkg::*;

	localparam int np   = `ETH_NUM_PATTERNS;
	localparam int offw = $clog2(`ETH_PAT_LEN);

	// One pattern byte, other bytes default to care 0
	typedef struct packed {
		int         pattern;
		int         offset;
		logic [7:0] value;
		logic [7:0] care;
	} pat_row_t;

	// Head byte i is seed + i, the rest random
	// tready goes low at the first hold row
	typedef struct packed {
		int            len;
		logic [7:0]    seed;
		logic          user;
		int            gap;
		logic [np-1:0] en;
		logic          hold;
	} frame_row_t;

	pat_row_t pat_table [4] = '{
		'{0, 0, 8'h5a, 8'hff},
		'{0, 3, 8'h5d, 8'hff},
		'{1, 15, 8'h0f, 8'h0f},
		'{2, 0, 8'h40, 8'hc0}
	};

	frame_row_t frame_table [11] = '{
		'{20, 8'h5a, 1'b0, 2, 3'b111, 1'b0},
		'{32, 8'h50, 1'b1, 0, 3'b111, 1'b0},
		'{10, 8'h5a, 1'b0, 3, 3'b111, 1'b0},
		'{16, 8'h10, 1'b0, 1, 3'b011, 1'b0},
		'{24, 8'h5a, 1'b0, 2, 3'b010, 1'b0},
		'{64, 8'hc3, 1'b1, 5, 3'b111, 1'b0},
		'{17, 8'h90, 1'b0, 0, 3'b110, 1'b0},
		'{48, 8'h5a, 1'b0, 6, 3'b111, 1'b1},
		'{40, 8'h50, 1'b1, 2, 3'b111, 1'b1},
		'{20, 8'h10, 1'b0, 2, 3'b111, 1'b1},
		'{30, 8'h5a, 1'b0, 2, 3'b111, 1'b1}
	};

	logic            clk = 1'b0;
	logic            reset;
	logic [7:0]      s_axis_tdata;
	logic            s_axis_tuser;
	logic            s_axis_tlast;
	logic            s_axis_tvalid;
	logic [7:0]      m_axis_tdata;
	logic            m_axis_tuser;
	logic            m_axis_tlast;
	logic            m_axis_tvalid;
	logic            m_axis_tready;
	logic            cfg_we;
	logic [1:0]      cfg_pattern;
	logic [offw-1:0] cfg_offset;
	eth_pat_byte_t   cfg_byte;
	logic [np-1:0]   match_en;
	logic [63:0]     current_time;
	logic            evt_valid;
	logic            evt_ready;
	logic [63:0]     evt_time;
	logic [np-1:0]   evt_mask;
	logic [15:0]     drop_count;

	// Reference model state
	logic [7:0]      pat_val [np][`ETH_PAT_LEN];
	logic [7:0]      pat_care [np][`ETH_PAT_LEN];
	eth_beat_t       exp_beats [$];
	eth_match_evt_t  exp_evts [$];
	eth_beat_t       got_beat;
	eth_match_evt_t  got_evt;
	int              spent = 0;
	int              returned = 0;
	int              model_drops = 0;
	int              beat_errors = 0;
	int              event_errors = 0;
	int              count_errors = 0;
	int              other_errors = 0;
	int              cycles = 0;
	int              cycle_limit = 100000;
	int              idle_run = 0;
	logic            after_last = 1'b0;

	always #20 clk = ~clk;

	eth_frame_detector u_eth_frame_detector (
		.s_axi_clk     (clk),
		.reset         (reset),
		.s_axis_tdata  (s_axis_tdata),
		.s_axis_tuser  (s_axis_tuser),
		.s_axis_tlast  (s_axis_tlast),
		.s_axis_tvalid (s_axis_tvalid),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tuser  (m_axis_tuser),
		.m_axis_tlast  (m_axis_tlast),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tready (m_axis_tready),
		.cfg_we        (cfg_we),
		.cfg_pattern   (cfg_pattern),
		.cfg_offset    (cfg_offset),
		.cfg_byte      (cfg_byte),
		.match_en      (match_en),
		.current_time  (current_time),
		.evt_valid     (evt_valid),
		.evt_ready     (evt_ready),
		.evt_time      (evt_time),
		.evt_mask      (evt_mask),
		.drop_count    (drop_count)
	);

	task automatic check_beat(input eth_beat_t got, input eth_beat_t exp);
		if (got !== exp) begin
			beat_errors++;
			$display("FAIL m_axis {tdata,tuser,tlast}: got %h expected %h", got, exp);
		end
	endtask

	task automatic check_event(input eth_match_evt_t got, input eth_match_evt_t exp);
		if (got !== exp) begin
			event_errors++;
			$display("FAIL evt_time/evt_mask: got %h/%h expected %h/%h",
				got.stamp, got.mask, exp.stamp, exp.mask);
		end
	endtask

	task automatic check_count(input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			count_errors++;
			$display("FAIL drop_count: got %h expected %h", got, exp);
		end
	endtask

	// All input changes happen just after the falling edge
	task automatic step_cycle();
		@(negedge clk);
		current_time  = current_time + 64'd1;
		s_axis_tvalid = 1'b0;
		s_axis_tlast  = 1'b0;
		s_axis_tuser  = 1'b0;
		cfg_we        = 1'b0;
	endtask

	task automatic write_patterns();
		for (int p = 0; p < np; p++) begin
			for (int o = 0; o < `ETH_PAT_LEN; o++) begin
				pat_val[p][o]  = 8'h00;
				pat_care[p][o] = 8'h00;
			end
		end
		foreach (pat_table[r]) begin
			pat_val[pat_table[r].pattern][pat_table[r].offset]  = pat_table[r].value;
			pat_care[pat_table[r].pattern][pat_table[r].offset] = pat_table[r].care;
		end
		// Every byte written so no entry is left unknown
		for (int p = 0; p < np; p++) begin
			for (int o = 0; o < `ETH_PAT_LEN; o++) begin
				step_cycle();
				cfg_we      = 1'b1;
				cfg_pattern = 2'(p);
				cfg_offset  = offw'(o);
				cfg_byte    = '{value: pat_val[p][o], care: pat_care[p][o]};
			end
		end
	endtask

	task automatic send_frame(input frame_row_t row);
		logic          admit;
		logic [np-1:0] hit;
		logic [63:0]   stamp;
		logic [7:0]    d;
		eth_beat_t     b;
		repeat (row.gap) step_cycle();
		step_cycle();
		// Whole frame in only with room for a maximum frame
		admit = (`ETH_FIFO_DEPTH - spent + returned) >= `ETH_MAX_FRAME;
		if (admit)
			spent += row.len;
		else
			model_drops++;
		stamp    = current_time;
		hit      = row.en;
		match_en = row.en;
		for (int i = 0; i < row.len; i++) begin
			if (i > 0)
				step_cycle();
			if (i < `ETH_PAT_LEN)
				d = row.seed + 8'(i);
			else
				d = 8'($urandom);
			// Any cared bit that differs kills the pattern
			if (i < `ETH_PAT_LEN) begin
				for (int p = 0; p < np; p++) begin
					if (((d ^ pat_val[p][i]) & pat_care[p][i]) != 8'h00)
						hit[p] = 1'b0;
				end
			end
			b = '{data: d, user: row.user && (i == row.len - 1), last: (i == row.len - 1)};
			s_axis_tdata  = b.data;
			s_axis_tuser  = b.user;
			s_axis_tlast  = b.last;
			s_axis_tvalid = 1'b1;
			if (admit)
				exp_beats.push_back(b);
		end
		// Events come from the raw stream, dropped frames too
		if (row.len >= `ETH_PAT_LEN && hit != '0)
			exp_evts.push_back('{stamp: stamp, mask: hit});
	endtask

	task automatic wait_drain();
		while (exp_beats.size() != 0 || exp_evts.size() != 0)
			step_cycle();
		repeat (4) step_cycle();
	endtask

	function automatic int run_limit();
		int total;
		total = 0;
		foreach (frame_table[f])
			total += 4 * frame_table[f].len + frame_table[f].gap;
		return total + np * `ETH_PAT_LEN + 200;
	endfunction

	// Transmit stream, gap and event monitor
	always @(posedge clk) begin
		if (!reset) begin
			if (m_axis_tvalid && after_last && idle_run < `ETH_IFG) begin
				other_errors++;
				$display("Transmit restarted after only %0d idle cycles", idle_run);
			end
			if (m_axis_tvalid)
				after_last = 1'b0;
			else
				idle_run++;
			if (m_axis_tvalid && m_axis_tready) begin
				returned++;
				got_beat = '{data: m_axis_tdata, user: m_axis_tuser, last: m_axis_tlast};
				if (exp_beats.size() == 0) begin
					other_errors++;
					$display("Beat on m_axis when none was expected");
				end else begin
					check_beat(got_beat, exp_beats.pop_front());
				end
				if (m_axis_tlast) begin
					after_last = 1'b1;
					idle_run   = 0;
				end
			end
			if (evt_valid && evt_ready) begin
				got_evt = '{stamp: evt_time, mask: evt_mask};
				if (exp_evts.size() == 0) begin
					other_errors++;
					$display("Event popped when none was expected");
				end else begin
					check_event(got_evt, exp_evts.pop_front());
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Timeout at cycle %0d, outputs never drained", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'h4025));
		reset         = 1'b1;
		s_axis_tdata  = 8'h00;
		s_axis_tuser  = 1'b0;
		s_axis_tlast  = 1'b0;
		s_axis_tvalid = 1'b0;
		m_axis_tready = 1'b1;
		cfg_we        = 1'b0;
		cfg_pattern   = 2'd0;
		cfg_offset    = '0;
		cfg_byte      = '0;
		match_en      = '0;
		current_time  = 64'h0000_1000_0000_0000;
		evt_ready     = 1'b1;
		cycle_limit   = run_limit();
		repeat (3) step_cycle();
		reset = 1'b0;
		write_patterns();
		foreach (frame_table[f]) begin
			// Back-pressure starts from a drained pipeline
			if (frame_table[f].hold && m_axis_tready) begin
				wait_drain();
				m_axis_tready = 1'b0;
			end
			send_frame(frame_table[f]);
		end
		repeat (8) step_cycle();
		m_axis_tready = 1'b1;
		wait_drain();
		repeat (20) step_cycle();
		check_count(drop_count, 16'(model_drops));
		$display("Errors: beat %0d, event %0d, drop count %0d, other %0d",
			beat_errors, event_errors, count_errors, other_errors);
		if (beat_errors + event_errors + count_errors + other_errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+include
rtl/eth_frame_pkg.sv
rtl/eth_beat_if.sv
rtl/eth_frame_fifo.sv
rtl/eth_frame_rx.sv
rtl/eth_frame_loop.sv
rtl/eth_frame_tx.sv
rtl/eth_frame_pattern_mem.sv
rtl/eth_frame_matcher.sv
rtl/eth_frame_detector.sv
tests/eth_frame_detector_sva.sv
tests/eth_frame_detector_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = eth_frame_detector_tb
FILELIST = filelist.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
